// ==== hdl/alu_op_decoder.sv ====
`timescale 1ns/1ps

module alu_op_decoder (
    input  rv_decode_pkg::opcode_e opcode,
    input  logic [2:0]             funct3,
    input  logic                   add_rshift_type,
    output rv_decode_pkg::alu_op_e alu_op
);

    import rv_decode_pkg::*;

    logic is_rtype;

    assign is_rtype = (opcode == OPC_ARI_RTYPE);

    always_comb begin
        case (opcode)
            OPC_ARI_RTYPE, OPC_ARI_ITYPE: begin
                case (funct3)
                    3'b000:  alu_op = (is_rtype && add_rshift_type) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = add_rshift_type ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                alu_op = ALU_COPY_B;
            end
            OPC_BRANCH: begin
                alu_op = ALU_SUB;  // Compare by subtraction
            end
            default: begin
                alu_op = ALU_ADD;  // Address and PC arithmetic
            end
        endcase
    end

endmodule

// ==== hdl/decode_read.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_read (
    input  logic                   flush,
    input  logic [`XLEN-1:0]       instr,
    input  logic                   s2_reg_we,
    input  logic                   s2_mem_rr,
    input  logic [`REG_ADDR_W-1:0] s2_rd,
    input  logic                   s3_reg_we,
    input  logic                   s3_mem_rr,
    input  logic [`REG_ADDR_W-1:0] s3_rd,
    output rv_decode_pkg::alu_op_e alu_op,
    output logic                   is_jump,
    output logic                   is_branch,
    output logic [2:0]             funct3,
    output logic                   a_sel_reg,
    output logic                   b_sel_reg,
    output logic                   reg_we,
    output logic                   mem_we,
    output logic                   mem_rr,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       imm,
    output logic                   read_bubble,
    output logic                   csr_write
);

    import rv_decode_pkg::*;

    opcode_e    opcode;
    logic [6:0] funct7;
    logic       s2_hazard;
    logic       s3_hazard;

    // Load in flight that writes a register the current instruction reads
    function automatic logic stage_hazard(
        input logic                   ld_we,
        input logic                   ld_rr,
        input logic [`REG_ADDR_W-1:0] ld_rd,
        input logic                   use_a,
        input logic                   use_b,
        input logic [`REG_ADDR_W-1:0] src_a,
        input logic [`REG_ADDR_W-1:0] src_b
    );
        logic hit_a;
        logic hit_b;
        hit_a = use_a && (src_a != '0) && (src_a == ld_rd);
        hit_b = use_b && (src_b != '0) && (src_b == ld_rd);
        return ld_rr && ld_we && (hit_a || hit_b);
    endfunction

    instr_decoder u_instr_decoder (
        .instr  (instr),
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .imm    (imm)
    );

    alu_op_decoder u_alu_op_decoder (
        .opcode          (opcode),
        .funct3          (funct3),
        .add_rshift_type (funct7[5]),
        .alu_op          (alu_op)
    );

    // ==================================================================
    // Control strobes, unknown opcodes give all zeros
    // ==================================================================
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jump   = (opcode == OPC_JAL) || (opcode == OPC_JALR) || is_branch;
    assign a_sel_reg = (opcode == OPC_STORE) || (opcode == OPC_LOAD)
                    || (opcode == OPC_ARI_RTYPE) || (opcode == OPC_ARI_ITYPE)
                    || (opcode == OPC_CSR) || (opcode == OPC_JALR);
    assign b_sel_reg = (opcode == OPC_ARI_RTYPE);
    assign reg_we    = (opcode == OPC_LUI) || (opcode == OPC_AUIPC) || (opcode == OPC_JAL)
                    || (opcode == OPC_JALR) || (opcode == OPC_LOAD)
                    || (opcode == OPC_ARI_ITYPE) || (opcode == OPC_ARI_RTYPE);
    assign mem_we    = (opcode == OPC_STORE);
    assign mem_rr    = (opcode == OPC_LOAD);
    assign csr_write = (opcode == OPC_CSR);

    // Branches compare both sources
    assign s2_hazard = stage_hazard(s2_reg_we, s2_mem_rr, s2_rd,
                                    a_sel_reg || is_branch, b_sel_reg || is_branch, rs1, rs2);
    assign s3_hazard = stage_hazard(s3_reg_we, s3_mem_rr, s3_rd,
                                    a_sel_reg || is_branch, b_sel_reg || is_branch, rs1, rs2);

    assign read_bubble = !flush && (s2_hazard || s3_hazard);

endmodule

// ==== hdl/decode_stage_top.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_stage_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_valid,
    input  logic [`XLEN-1:0]            instr,
    input  logic                        stall,
    input  logic                        flush,
    output rv_decode_pkg::alu_op_e      alu_op,
    output logic                        is_jump,
    output logic                        is_branch,
    output logic [2:0]                  funct3,
    output logic                        a_sel_reg,
    output logic                        b_sel_reg,
    output logic                        reg_we,
    output logic                        mem_we,
    output logic                        mem_rr,
    output logic [`REG_ADDR_W-1:0]      rd,
    output logic [`REG_ADDR_W-1:0]      rs1,
    output logic [`REG_ADDR_W-1:0]      rs2,
    output logic [`XLEN-1:0]            imm,
    output logic                        read_bubble,
    output logic                        csr_write,
    output logic                        issue,
    output rv_decode_pkg::issue_state_e state,
    output logic [`CNT_W-1:0]           interlock_count,
    output logic [`CNT_W-1:0]           hold_count
);

    logic [`REG_ADDR_W-1:0] s2_rd, s3_rd;
    logic                   s2_reg_we, s2_mem_rr;
    logic                   s3_reg_we, s3_mem_rr;
    logic                   shift_en, insert_bubble;
    logic                   count_interlock, count_hold;

    // ==================================================================
    // Decode and hazard check
    // ==================================================================
    decode_read u_decode_read (
        .flush       (flush),
        .instr       (instr),
        .s2_reg_we   (s2_reg_we),
        .s2_mem_rr   (s2_mem_rr),
        .s2_rd       (s2_rd),
        .s3_reg_we   (s3_reg_we),
        .s3_mem_rr   (s3_mem_rr),
        .s3_rd       (s3_rd),
        .alu_op      (alu_op),
        .is_jump     (is_jump),
        .is_branch   (is_branch),
        .funct3      (funct3),
        .a_sel_reg   (a_sel_reg),
        .b_sel_reg   (b_sel_reg),
        .reg_we      (reg_we),
        .mem_we      (mem_we),
        .mem_rr      (mem_rr),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .read_bubble (read_bubble),
        .csr_write   (csr_write)
    );

    inflight_tracker u_inflight_tracker (
        .clk           (clk),
        .arst_n        (arst_n),
        .shift_en      (shift_en),
        .insert_bubble (insert_bubble),
        .rd            (rd),
        .reg_we        (reg_we),
        .mem_rr        (mem_rr),
        .s2_rd         (s2_rd),
        .s2_reg_we     (s2_reg_we),
        .s2_mem_rr     (s2_mem_rr),
        .s3_rd         (s3_rd),
        .s3_reg_we     (s3_reg_we),
        .s3_mem_rr     (s3_mem_rr)
    );

    // ==================================================================
    // Issue control and statistics
    // ==================================================================
    issue_fsm u_issue_fsm (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr_valid     (instr_valid),
        .stall           (stall),
        .flush           (flush),
        .read_bubble     (read_bubble),
        .issue           (issue),
        .shift_en        (shift_en),
        .insert_bubble   (insert_bubble),
        .count_interlock (count_interlock),
        .count_hold      (count_hold),
        .state           (state)
    );

    stall_counter u_stall_counter (
        .clk             (clk),
        .arst_n          (arst_n),
        .count_interlock (count_interlock),
        .count_hold      (count_hold),
        .interlock_count (interlock_count),
        .hold_count      (hold_count)
    );

endmodule

// ==== hdl/inflight_tracker.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module inflight_tracker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   shift_en,
    input  logic                   insert_bubble,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   reg_we,
    input  logic                   mem_rr,
    output logic [`REG_ADDR_W-1:0] s2_rd,
    output logic                   s2_reg_we,
    output logic                   s2_mem_rr,
    output logic [`REG_ADDR_W-1:0] s3_rd,
    output logic                   s3_reg_we,
    output logic                   s3_mem_rr
);

    // A bubble clears the write strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_reg_we <= 1'b0;
            s2_mem_rr <= 1'b0;
            s3_reg_we <= 1'b0;
            s3_mem_rr <= 1'b0;
        end else if (shift_en) begin
            s2_reg_we <= reg_we && !insert_bubble;
            s2_mem_rr <= mem_rr && !insert_bubble;
            s3_reg_we <= s2_reg_we;
            s3_mem_rr <= s2_mem_rr;
        end
    end

    // Destination indices move with the strobes
    always_ff @(posedge clk) begin
        if (shift_en) begin
            s2_rd <= rd;
            s3_rd <= s2_rd;
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]       instr,
    output rv_decode_pkg::opcode_e opcode,
    output logic [2:0]             funct3,
    output logic [6:0]             funct7,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       imm
);

    import rv_decode_pkg::*;

    // Fixed field positions
    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];   // Also shamt for immediate shifts
    assign funct7 = instr[31:25];

    // ==================================================================
    // Immediate format select, sign bit is always instr[31]
    // ==================================================================
    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_ARI_ITYPE, OPC_CSR: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};  // I
            end
            OPC_STORE: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};  // S
            end
            OPC_BRANCH: begin
                imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};  // B
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};  // U
            end
            OPC_JAL: begin
                imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};  // J
            end
            default: begin
                imm = '0;  // R-type and unknown opcodes
            end
        endcase
    end

endmodule

// ==== hdl/issue_fsm.sv ====
`timescale 1ns/1ps

module issue_fsm (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_valid,
    input  logic                        stall,
    input  logic                        flush,
    input  logic                        read_bubble,
    output logic                        issue,
    output logic                        shift_en,
    output logic                        insert_bubble,
    output logic                        count_interlock,
    output logic                        count_hold,
    output rv_decode_pkg::issue_state_e state
);

    import rv_decode_pkg::*;

    issue_state_e action;

    // ==================================================================
    // Action of this cycle, flush over stall over hazard
    // ==================================================================
    always_comb begin
        if (flush)
            action = ST_FLUSH;
        else if (stall)
            action = ST_HOLD;
        else if (read_bubble)
            action = ST_INTERLOCK;
        else
            action = ST_ISSUE;
    end

    assign issue           = (action == ST_ISSUE) && instr_valid;
    assign shift_en        = (action != ST_HOLD);   // Tracker frozen under back-pressure
    assign insert_bubble   = !issue;
    assign count_interlock = (action == ST_INTERLOCK);
    assign count_hold      = (action == ST_HOLD);

    // Last action taken, visible at the top
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= ST_FLUSH;
        else
            state <= action;
    end

endmodule

// ==== hdl/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// ======================================================================
// Datapath widths
// ======================================================================

// Instruction and immediate width
`define XLEN 32

// Register index, x0..x31
`define REG_ADDR_W 5

// ALU operation code
`define ALU_OP_W 4

// Each stall counter, saturating
`define CNT_W 16

`endif

// ==== hdl/rv_decode_pkg.sv ====
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    // ==================================================================
    // RV32I major opcodes, instr[6:0]
    // ==================================================================
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_ARI_RTYPE = 7'b0110011,
        OPC_CSR       = 7'b1110011
    } opcode_e;

    // ==================================================================
    // ALU operations
    // ==================================================================
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_COPY_B = 4'd10  // Pass operand B through, for LUI
    } alu_op_e;

    // Action taken by the issue logic in a cycle
    typedef enum logic [1:0] {
        ST_ISSUE     = 2'd0,
        ST_INTERLOCK = 2'd1,
        ST_HOLD      = 2'd2,
        ST_FLUSH     = 2'd3
    } issue_state_e;

endpackage

// ==== hdl/stall_counter.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module stall_counter (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              count_interlock,
    input  logic              count_hold,
    output logic [`CNT_W-1:0] interlock_count,
    output logic [`CNT_W-1:0] hold_count
);

    logic [1:0]             inc;
    logic [1:0][`CNT_W-1:0] cnt;

    assign inc = {count_hold, count_interlock};

    // Both lanes saturate at all ones
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (inc[i] && !(&cnt[i]))
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign interlock_count = cnt[0];
    assign hold_count      = cnt[1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module decode_stage_tb \
    -o decode_stage_sim

./obj_dir/decode_stage_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see sim.log"
    exit 1
fi

// ==== sources.f ====
+incdir+hdl
hdl/rv_decode_pkg.sv
hdl/instr_decoder.sv
hdl/alu_op_decoder.sv
hdl/decode_read.sv
hdl/inflight_tracker.sv
hdl/issue_fsm.sv
hdl/stall_counter.sv
hdl/decode_stage_top.sv
tb/decode_stage_checker.sv
tb/decode_stage_tb.sv

// ==== tb/decode_stage_checker.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_stage_checker (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        run_done,
    input  logic                        stall,
    input  logic                        flush,
    input  rv_decode_pkg::alu_op_e      alu_op,
    input  rv_decode_pkg::alu_op_e      exp_alu_op,
    input  logic [2:0]                  funct3, exp_funct3,
    input  logic [`REG_ADDR_W-1:0]      rd, rs1, rs2, exp_rd, exp_rs1, exp_rs2,
    input  logic [`XLEN-1:0]            imm, exp_imm,
    input  logic                        is_jump, is_branch, a_sel_reg, b_sel_reg,
    input  logic                        reg_we, mem_we, mem_rr, csr_write,
    input  logic                        exp_is_jump, exp_is_branch, exp_a_sel_reg,
    input  logic                        exp_b_sel_reg, exp_reg_we, exp_mem_we,
    input  logic                        exp_mem_rr, exp_csr_write,
    input  logic                        read_bubble, exp_read_bubble, issue, exp_issue,
    input  rv_decode_pkg::issue_state_e state, exp_state,
    input  logic [`CNT_W-1:0]           interlock_count, hold_count,
    input  logic [`CNT_W-1:0]           exp_interlock_count, exp_hold_count,
    output int                          error_count,
    output int                          check_count
);

    import rv_decode_pkg::*;

    string test_name [6] = '{"field_decode", "control_decode", "load_use_interlock",
                             "flush", "back_pressure", "counters"};
    int    checks [6];
    int    errors [6];
    logic  reported = 1'b0;

    task automatic check(input int t, input string sig, input logic [31:0] exp,
                         input logic [31:0] act);
        checks[t]   = checks[t] + 1;
        check_count = check_count + 1;
        if (exp !== act) begin
            errors[t]   = errors[t] + 1;
            error_count = error_count + 1;
            $display("Error %s %s: expected 0x%0h, actual 0x%0h", test_name[t], sig, exp, act);
        end
    endtask

    // Outputs settle half a cycle after the inputs change
    always @(negedge clk) begin
        int hazard_cat;
        int state_cat;
        if (arst_n && !run_done) begin
            check(0, "rd", 32'(exp_rd), 32'(rd));
            check(0, "rs1", 32'(exp_rs1), 32'(rs1));
            check(0, "rs2", 32'(exp_rs2), 32'(rs2));
            check(0, "funct3", 32'(exp_funct3), 32'(funct3));
            check(0, "imm", exp_imm, imm);
            check(1, "alu_op", 32'(exp_alu_op), 32'(alu_op));
            check(1, "is_jump", 32'(exp_is_jump), 32'(is_jump));
            check(1, "is_branch", 32'(exp_is_branch), 32'(is_branch));
            check(1, "a_sel_reg", 32'(exp_a_sel_reg), 32'(a_sel_reg));
            check(1, "b_sel_reg", 32'(exp_b_sel_reg), 32'(b_sel_reg));
            check(1, "reg_we", 32'(exp_reg_we), 32'(reg_we));
            check(1, "mem_we", 32'(exp_mem_we), 32'(mem_we));
            check(1, "mem_rr", 32'(exp_mem_rr), 32'(mem_rr));
            check(1, "csr_write", 32'(exp_csr_write), 32'(csr_write));
            hazard_cat = flush ? 3 : (stall ? 4 : 2);
            check(hazard_cat, "read_bubble", 32'(exp_read_bubble), 32'(read_bubble));
            check(hazard_cat, "issue", 32'(exp_issue), 32'(issue));
            // State shows the action of the cycle before
            state_cat = (exp_state == ST_FLUSH) ? 3 : ((exp_state == ST_HOLD) ? 4 : 2);
            check(state_cat, "state", 32'(exp_state), 32'(state));
        end else if (run_done && !reported) begin
            check(5, "interlock_count", 32'(exp_interlock_count), 32'(interlock_count));
            check(5, "hold_count", 32'(exp_hold_count), 32'(hold_count));
            for (int t = 0; t < 6; t++)
                $display("Test %0d %s: %0d checks, %0d errors, %s", t + 1, test_name[t],
                         checks[t], errors[t], (errors[t] == 0) ? "ok" : "failed");
            reported = 1'b1;
        end
    end

endmodule

// ==== tb/decode_stage_tb.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_stage_tb;

    import rv_decode_pkg::*;

    localparam int     N_CYCLES   = 3000;
    localparam int     RST_CYCLES = 8;
    localparam longint TIMEOUT_NS = (N_CYCLES + RST_CYCLES + 100) * 20;

    logic                   clk, arst_n, instr_valid, stall, flush, run_done;
    logic [`XLEN-1:0]       instr, imm, exp_imm;
    alu_op_e                alu_op, exp_alu_op;
    logic [2:0]             funct3, exp_funct3;
    logic [`REG_ADDR_W-1:0] rd, rs1, rs2, exp_rd, exp_rs1, exp_rs2;
    logic                   is_jump, is_branch, a_sel_reg, b_sel_reg, reg_we;
    logic                   mem_we, mem_rr, csr_write, read_bubble, issue;
    logic                   exp_is_jump, exp_is_branch, exp_a_sel_reg, exp_b_sel_reg;
    logic                   exp_reg_we, exp_mem_we, exp_mem_rr, exp_csr_write;
    logic                   exp_read_bubble, exp_issue;
    issue_state_e           state, exp_state, m_action;
    logic [`CNT_W-1:0]      interlock_count, hold_count, exp_interlock_count, exp_hold_count;
    int                     error_count, check_count;

    // Model copy of the loads in the two older stages
    logic [`REG_ADDR_W-1:0] m_s2_rd, m_s3_rd;
    logic                   m_s2_load, m_s3_load;

    opcode_e opc_list [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                               OPC_LOAD, OPC_STORE, OPC_ARI_ITYPE, OPC_ARI_RTYPE, OPC_CSR};

    decode_stage_top uut (.*);

    decode_stage_checker chk (.*);

    // ==================================================================
    // Reference model
    // ==================================================================
    // Immediate placed at the top of the word and sign-shifted down
    function automatic logic [`XLEN-1:0] imm_of(input logic [`XLEN-1:0] ins);
        case (ins[6:0])
            OPC_JALR, OPC_LOAD, OPC_ARI_ITYPE, OPC_CSR:
                return $signed({ins[31:20], 20'b0}) >>> 20;
            OPC_STORE:
                return $signed({ins[31:25], ins[11:7], 20'b0}) >>> 20;
            OPC_BRANCH:
                return $signed({ins[31], ins[7], ins[30:25], ins[11:8], 20'b0}) >>> 19;
            OPC_LUI, OPC_AUIPC:
                return {ins[31:12], 12'b0};
            OPC_JAL:
                return $signed({ins[31], ins[19:12], ins[20], ins[30:21], 12'b0}) >>> 11;
            default:
                return '0;
        endcase
    endfunction

    function automatic alu_op_e alu_of(input logic [`XLEN-1:0] ins);
        logic [6:0] op;
        op = ins[6:0];
        if (op == OPC_LUI)
            return ALU_COPY_B;
        if (op == OPC_BRANCH)
            return ALU_SUB;
        if (!(op inside {OPC_ARI_RTYPE, OPC_ARI_ITYPE}))
            return ALU_ADD;
        case (ins[14:12])
            3'd0:    return (ins[30] && op == OPC_ARI_RTYPE) ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ins[30] ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        logic [6:0] op;
        logic       reads_a;
        logic       reads_b;
        logic       hit2;
        logic       hit3;
        op            = instr[6:0];
        exp_rd        = instr[11:7];
        exp_funct3    = instr[14:12];
        exp_rs1       = instr[19:15];
        exp_rs2       = instr[24:20];
        exp_imm       = imm_of(instr);
        exp_alu_op    = alu_of(instr);
        exp_is_branch = (op == OPC_BRANCH);
        exp_is_jump   = op inside {OPC_JAL, OPC_JALR, OPC_BRANCH};
        exp_a_sel_reg = op inside {OPC_STORE, OPC_LOAD, OPC_ARI_RTYPE, OPC_ARI_ITYPE,
                                   OPC_CSR, OPC_JALR};
        exp_b_sel_reg = (op == OPC_ARI_RTYPE);
        exp_reg_we    = op inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD,
                                   OPC_ARI_ITYPE, OPC_ARI_RTYPE};
        exp_mem_we    = (op == OPC_STORE);
        exp_mem_rr    = (op == OPC_LOAD);
        exp_csr_write = (op == OPC_CSR);
        reads_a = exp_a_sel_reg || exp_is_branch;  // Branches read both sources
        reads_b = exp_b_sel_reg || exp_is_branch;
        hit2 = m_s2_load && ((reads_a && exp_rs1 != 0 && exp_rs1 == m_s2_rd)
                          || (reads_b && exp_rs2 != 0 && exp_rs2 == m_s2_rd));
        hit3 = m_s3_load && ((reads_a && exp_rs1 != 0 && exp_rs1 == m_s3_rd)
                          || (reads_b && exp_rs2 != 0 && exp_rs2 == m_s3_rd));
        exp_read_bubble = !flush && (hit2 || hit3);
        if (flush)
            m_action = ST_FLUSH;
        else if (stall)
            m_action = ST_HOLD;
        else if (exp_read_bubble)
            m_action = ST_INTERLOCK;
        else
            m_action = ST_ISSUE;
        exp_issue = (m_action == ST_ISSUE) && instr_valid;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_s2_load           <= 1'b0;
            m_s3_load           <= 1'b0;
            m_s2_rd             <= '0;
            m_s3_rd             <= '0;
            exp_state           <= ST_FLUSH;
            exp_interlock_count <= '0;
            exp_hold_count      <= '0;
        end else begin
            exp_state <= m_action;
            if (m_action != ST_HOLD) begin
                m_s2_load <= exp_issue && exp_mem_rr;
                m_s2_rd   <= exp_rd;
                m_s3_load <= m_s2_load;
                m_s3_rd   <= m_s2_rd;
            end
            if (m_action == ST_INTERLOCK && exp_interlock_count != '1)
                exp_interlock_count <= exp_interlock_count + 1'b1;
            if (m_action == ST_HOLD && exp_hold_count != '1)
                exp_hold_count <= exp_hold_count + 1'b1;
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    function automatic logic [`XLEN-1:0] rand_instr();
        logic [31:0] r;
        logic [31:0] r2;
        logic [6:0]  op;
        int          idx;
        r   = $urandom;
        r2  = $urandom;
        idx = r[31:16] % 10;
        // Low bits 00 never match an RV32I major opcode
        op  = (r[3:0] == 4'd0) ? {r[10:6], 2'b00} : opc_list[idx];
        return {r2[9:3], 3'b0, r[16:15], 3'b0, r[14:13], r2[2:0], 3'b0, r[12:11], op};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        void'($urandom(99));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        run_done    = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < N_CYCLES; i++) begin
            @(posedge clk);
            instr       <= rand_instr();
            instr_valid <= ($urandom % 10) != 0;
            stall       <= ($urandom % 100) < 15;
            flush       <= ($urandom % 100) < 5;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;
        stall       <= 1'b0;
        flush       <= 1'b0;
        run_done    <= 1'b1;
        @(negedge clk);
        #1;
        $display("Totals: %0d checks, %0d errors", check_count, error_count);
        if (check_count == 0)
            $display("No checks ran, reset never released or checker idle");
        if (error_count == 0 && check_count > 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout: run did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
